// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_sng_rank
RTL_TOP   ?= sng_rank_top
FLIST     ?= sng_rank.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rank_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module rank_select #(
   parameter int STRIDE = sc_pkg::DEFAULT_STRIDE
) (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  load,
   input  wire sc_pkg::rank_t   rank,
   input  wire [STRIDE*sc_pkg::NUM_OPERANDS-1:0] hits,
   output logic [STRIDE-1:0]    sn_out
);

   localparam int N     = sc_pkg::NUM_OPERANDS;
   localparam int CNT_W = $clog2(N + 1);

   typedef logic [CNT_W-1:0] ones_t;

   sc_pkg::rank_t rank_q;
   ones_t         need;
   ones_t         ones [STRIDE];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rank_q <= sc_pkg::RANK_MIN;
      end else if (load) begin
         rank_q <= rank;
      end
   end

   // min needs every bit set, max needs just one
   assign need = ones_t'(N) - ones_t'(rank_q);

   always_comb begin
      for (int j = 0; j < STRIDE; j++) begin
         ones[j] = '0;
         for (int i = 0; i < N; i++) begin
            ones[j] = ones[j] + ones_t'(hits[j*N + i]);
         end
         sn_out[j] = (ones[j] >= need);
      end
   end

   // an out of range code would give need <= 0 and a stuck-high stream
   a_rank_legal : assert property (@(posedge clk) disable iff (!rst_n)
      rank_q <= sc_pkg::RANK_MAX)
      else $error("illegal rank code %0d captured", rank_q);

endmodule

`default_nettype wire

// ==== sc_pkg.sv ====
`default_nettype none

package sc_pkg;

   // operand, counter and result width
   parameter int SAMPLE_W = 8;

   // inputs to the order-statistic network
   parameter int NUM_OPERANDS = 5;

   // lanes per cycle when the top level leaves STRIDE alone
   parameter int DEFAULT_STRIDE = 2;

   typedef logic [SAMPLE_W-1:0] sample_t;

   typedef struct packed {
      sample_t op0;
      sample_t op1;
      sample_t op2;
      sample_t op3;
      sample_t op4;
   } operand_set_t;

   // index counts from the smallest operand
   typedef enum logic [2:0] {
      RANK_MIN             = 3'd0,
      RANK_SECOND_SMALLEST = 3'd1,
      RANK_MID             = 3'd2,
      RANK_SECOND_LARGEST  = 3'd3,
      RANK_MAX             = 3'd4
   } rank_t;

endpackage

`default_nettype wire

// ==== sng_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sng_counter #(
   parameter int STRIDE = sc_pkg::DEFAULT_STRIDE
) (
   input  wire             clk,
   input  wire             rst_n,
   input  wire             run,
   input  wire             load,
   output sc_pkg::sample_t count,
   output logic            last
);

   localparam sc_pkg::sample_t STEP     = sc_pkg::sample_t'(STRIDE);
   localparam sc_pkg::sample_t LAST_VAL = sc_pkg::sample_t'(2 ** sc_pkg::SAMPLE_W - STRIDE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else if (load) begin
         count <= '0;
      end else if (run) begin
         count <= count + STEP;  // wraps to zero after the last beat
      end
   end

   // lanes 1..STRIDE-1 cover the rest of the range
   assign last = (count == LAST_VAL);

   a_count_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      (int'(count) % STRIDE) == 0)
      else $error("counter left the stride grid, count=%0d", count);

endmodule

`default_nettype wire

// ==== sng_rank.f ====
sc_pkg.sv
sng_run_ctrl.sv
sng_counter.sv
threshold_bank.sv
rank_select.sv
stream_accum.sv
sng_rank_top.sv
tb_sng_rank.sv

// ==== sng_rank_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sng_rank_top #(
   parameter int STRIDE = sc_pkg::DEFAULT_STRIDE
) (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        start,
   input  wire sc_pkg::operand_set_t  operands,
   input  wire sc_pkg::rank_t         rank,
   output logic                       busy,
   output logic                       sn_valid,
   output logic [STRIDE-1:0]          sn_out,
   output logic                       done,
   output sc_pkg::sample_t            result
);

   wire                                   load;
   wire                                   last;
   sc_pkg::sample_t                       count;
   wire [STRIDE*sc_pkg::NUM_OPERANDS-1:0] hits;

   // run level goes out directly as sn_valid
   sng_run_ctrl u_ctrl (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start),
      .last  (last),
      .load  (load),
      .run   (sn_valid),
      .busy  (busy),
      .done  (done)
   );

   sng_counter #(.STRIDE(STRIDE)) u_counter (
      .clk   (clk),
      .rst_n (rst_n),
      .run   (sn_valid),
      .load  (load),
      .count (count),
      .last  (last)
   );

   threshold_bank #(.STRIDE(STRIDE)) u_thresh (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load),
      .operands (operands),
      .count    (count),
      .hits     (hits)
   );

   rank_select #(.STRIDE(STRIDE)) u_rank (
      .clk    (clk),
      .rst_n  (rst_n),
      .load   (load),
      .rank   (rank),
      .hits   (hits),
      .sn_out (sn_out)
   );

   stream_accum #(.STRIDE(STRIDE)) u_accum (
      .clk    (clk),
      .rst_n  (rst_n),
      .load   (load),
      .run    (sn_valid),
      .sn_out (sn_out),
      .result (result)
   );

endmodule

`default_nettype wire

// ==== sng_run_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sng_run_ctrl (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  start,
   input  wire  last,
   output logic load,
   output logic run,
   output logic busy,
   output logic done
);

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } state_t;

   state_t state;
   state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = RUN;
            end
         end
         RUN: begin
            if (last) begin  // final beat of the sweep
               state_nxt = DONE;
            end
         end
         DONE:    state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign load = (state == IDLE) && start;  // start ignored while busy
   assign run  = (state == RUN);
   assign busy = (state != IDLE);
   assign done = (state == DONE);

   // the result is only complete once the stream has stopped
   a_done_after_run : assert property (@(posedge clk) disable iff (!rst_n)
      done |-> !run && $past(run) && $past(last))
      else $error("done raised without a finished sweep");

endmodule

`default_nettype wire

// ==== stream_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_accum #(
   parameter int STRIDE = sc_pkg::DEFAULT_STRIDE
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              load,
   input  wire              run,
   input  wire [STRIDE-1:0] sn_out,
   output sc_pkg::sample_t  result
);

   localparam int POP_W = $clog2(STRIDE + 1);
   localparam int SUM_W = sc_pkg::SAMPLE_W + 1;

   logic [POP_W-1:0] pop;
   logic [SUM_W-1:0] sum_nxt;

   always_comb begin
      pop = '0;
      for (int j = 0; j < STRIDE; j++) begin
         pop = pop + POP_W'(sn_out[j]);
      end
   end

   assign sum_nxt = {1'b0, result} + SUM_W'(pop);  // spare bit catches a wrap

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         result <= '0;
      end else if (load) begin
         result <= '0;
      end else if (run) begin
         result <= sum_nxt[sc_pkg::SAMPLE_W-1:0];
      end
   end

   // a full sweep of 256 references can give at most 255 ones
   a_no_wrap : assert property (@(posedge clk) disable iff (!rst_n)
      run |-> !sum_nxt[sc_pkg::SAMPLE_W])
      else $error("accumulator wrapped past 255");

endmodule

`default_nettype wire

// ==== tb_sng_rank.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sng_rank;

   localparam int STRIDE = sc_pkg::DEFAULT_STRIDE;
   localparam int P      = 256 / STRIDE;  // beats per sweep

   logic                 clk;
   logic                 rst_n;
   logic                 start;
   sc_pkg::operand_set_t operands;
   sc_pkg::rank_t        rank;
   logic                 busy;
   logic                 sn_valid;
   logic [STRIDE-1:0]    sn_out;
   logic                 done;
   sc_pkg::sample_t      result;

   sc_pkg::operand_set_t exp_ops;   // operands of the run in flight
   sc_pkg::rank_t        exp_rank;
   int                   cyc;
   int                   start_cyc;
   int                   beat;
   int                   seed;

   sng_rank_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .operands (operands),
      .rank     (rank),
      .busy     (busy),
      .sn_valid (sn_valid),
      .sn_out   (sn_out),
      .done     (done),
      .result   (result)
   );

   always #20 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic sc_pkg::sample_t ref_rank(sc_pkg::operand_set_t ops, sc_pkg::rank_t rk);
      sc_pkg::sample_t v [5];
      sc_pkg::sample_t t;
      v[0] = ops.op0;
      v[1] = ops.op1;
      v[2] = ops.op2;
      v[3] = ops.op3;
      v[4] = ops.op4;
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4 - i; j++) begin
            if (v[j] > v[j+1]) begin
               t      = v[j];
               v[j]   = v[j+1];
               v[j+1] = t;
            end
         end
      end
      return v[int'(rk)];  // index 0 is the smallest
   endfunction

   function automatic logic ref_lane(sc_pkg::operand_set_t ops, sc_pkg::rank_t rk,
                                     int b, int lane);
      return int'(ref_rank(ops, rk)) > (b * STRIDE + lane);
   endfunction

   task automatic check_sample(sc_pkg::sample_t got, sc_pkg::sample_t exp, string name);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "value compare error");
      end
   endtask

   task automatic check_bit(logic got, logic exp, string name);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "bit compare error");
      end
   endtask

   task automatic check_count(int got, int exp, string name);
      if (got != exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "cycle count error");
      end
   endtask

   // stream check on every beat of a sweep
   always @(negedge clk) begin
      if (sn_valid) begin
         check_bit(busy, 1'b1, "busy during sweep");
         for (int j = 0; j < STRIDE; j++) begin
            check_bit(sn_out[j], ref_lane(exp_ops, exp_rank, beat, j),
                      $sformatf("sn_out[%0d] beat %0d", j, beat));
         end
         beat = beat + 1;
      end else begin
         beat = 0;
      end
   end

   task automatic issue_start(sc_pkg::operand_set_t ops, sc_pkg::rank_t rk);
      exp_ops  = ops;
      exp_rank = rk;
      @(posedge clk);
      start    <= 1'b1;
      operands <= ops;
      rank     <= rk;
      @(posedge clk);  // this edge samples start
      start     <= 1'b0;
      start_cyc = cyc + 1;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      @(negedge clk);
      while (!done) begin
         n = n + 1;
         if (n > 300) begin
            $display("Timeout at %0t: done never came within 300 cycles", $time);
            $display("Test failed");
            $fatal(1, "timeout");
         end
         @(negedge clk);
      end
      check_count(cyc - start_cyc + 1, P + 1, "done latency");
      check_bit(busy, 1'b1, "busy at done");
      check_sample(result, ref_rank(exp_ops, exp_rank), "result");
   endtask

   task automatic run_and_check(sc_pkg::operand_set_t ops, sc_pkg::rank_t rk);
      issue_start(ops, rk);
      wait_done();
   endtask

   task automatic make_random(output sc_pkg::operand_set_t ops, output sc_pkg::rank_t rk);
      int r;
      ops.op0 = sc_pkg::sample_t'($random(seed));
      ops.op1 = sc_pkg::sample_t'($random(seed));
      ops.op2 = sc_pkg::sample_t'($random(seed));
      ops.op3 = sc_pkg::sample_t'($random(seed));
      ops.op4 = sc_pkg::sample_t'($random(seed));
      r       = $random(seed);
      rk      = sc_pkg::rank_t'((r & 32'h7fff_ffff) % 5);
   endtask

   initial begin
      sc_pkg::operand_set_t ops;
      sc_pkg::operand_set_t stray;
      sc_pkg::rank_t        rk;
      seed     = 32'hbddf_829d;
      clk      = 1'b0;
      rst_n    = 1'b0;
      start    = 1'b0;
      operands = '0;
      rank     = sc_pkg::RANK_MIN;
      cyc      = 0;
      beat     = 0;
      exp_ops  = '0;
      exp_rank = sc_pkg::RANK_MIN;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit(busy, 1'b0, "busy");
      check_bit(sn_valid, 1'b0, "sn_valid");
      check_bit(done, 1'b0, "done");
      check_sample(result, '0, "result after reset");

      ops = '{op0: 8'd40, op1: 8'd200, op2: 8'd7, op3: 8'd128, op4: 8'd99};
      for (int k = 0; k < 5; k++) begin
         run_and_check(ops, sc_pkg::rank_t'(k));
      end

      for (int k = 0; k < 40; k++) begin
         make_random(ops, rk);
         run_and_check(ops, rk);
      end

      // second start lands mid-sweep with other operands
      make_random(ops, rk);
      make_random(stray, rk);
      issue_start(ops, sc_pkg::RANK_MID);
      repeat (10) @(posedge clk);
      start    <= 1'b1;
      operands <= stray;
      rank     <= sc_pkg::RANK_MAX;
      @(posedge clk);
      start <= 1'b0;
      wait_done();
      make_random(ops, rk);
      run_and_check(ops, rk);  // begins in the cycle after done

      run_and_check('0, sc_pkg::RANK_MID);
      run_and_check('1, sc_pkg::RANK_SECOND_LARGEST);
      ops = '{op0: 8'd0, op1: 8'd255, op2: 8'd0, op3: 8'd255, op4: 8'd0};
      run_and_check(ops, sc_pkg::RANK_MIN);
      run_and_check(ops, sc_pkg::RANK_MAX);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== threshold_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module threshold_bank #(
   parameter int STRIDE = sc_pkg::DEFAULT_STRIDE
) (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        load,
   input  wire sc_pkg::operand_set_t  operands,
   input  wire sc_pkg::sample_t       count,
   output logic [STRIDE*sc_pkg::NUM_OPERANDS-1:0] hits
);

   localparam int N = sc_pkg::NUM_OPERANDS;

   sc_pkg::operand_set_t ops_q;
   sc_pkg::sample_t      op_arr [N];

   // cleared so the stream reads zero before the first run
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ops_q <= '0;
      end else if (load) begin
         ops_q <= operands;
      end
   end

   assign op_arr[0] = ops_q.op0;
   assign op_arr[1] = ops_q.op1;
   assign op_arr[2] = ops_q.op2;
   assign op_arr[3] = ops_q.op3;
   assign op_arr[4] = ops_q.op4;

   for (genvar j = 0; j < STRIDE; j++) begin : g_lane
      sc_pkg::sample_t lane_ref;

      assign lane_ref = count + sc_pkg::sample_t'(j);  // no overflow, count tops at 256-STRIDE

      for (genvar i = 0; i < N; i++) begin : g_op
         // unary bit of operand i
         assign hits[j*N + i] = (op_arr[i] > lane_ref);
      end
   end

endmodule

`default_nettype wire
